// ==== Makefile ====
# Verilator flow for the mesh link configuration block

VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= ecfg_tb
RTL_TOP    ?= ecfg_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= all tests passed
RTL_FILES  ?= logic/ecfg_pkg.sv logic/ecfg_regs.sv logic/ecfg_clkdiv.sv \
              logic/ecfg_reset_seq.sv logic/ecfg_id_filter.sv logic/ecfg_top.sv
LINT_FLAGS ?= --lint-only -Wall -Wno-fatal
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
SIM_ARGS   ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/ecfg_clkdiv.sv ====
/*
   tx/rx clock divider, one strobe every d+1 cycles per enabled channel
*/
`timescale 1ns/1ps
`default_nettype none

module ecfg_clkdiv (
   input  logic               sys_clk,
   input  logic               hard_reset,
   input  ecfg_pkg::clk_cfg_t clk_cfg,
   output logic               tx_strobe,
   output logic               rx_strobe
);

   import ecfg_pkg::*;

   div_t tx_cnt;
   div_t rx_cnt;

   // shared next-count rule for both channels
   function automatic div_t next_cnt(input logic en, input div_t cnt, input div_t div);
      div_t nxt;
      if (!en)
         nxt = '0;           // disabled, park at zero
      else if (cnt == '0)
         nxt = div;          // wrap, new divider picked up here
      else
         nxt = cnt - 1'b1;
      return nxt;
   endfunction

   //######################################################################
   // down counters
   //######################################################################
   always_ff @(posedge sys_clk) begin
      if (hard_reset) begin
         tx_cnt <= '0;
         rx_cnt <= '0;
      end else begin
         tx_cnt <= next_cnt(clk_cfg.tx_en, tx_cnt, clk_cfg.tx_div);
         rx_cnt <= next_cnt(clk_cfg.rx_en, rx_cnt, clk_cfg.rx_div);
      end
   end

   // strobe on the reload cycle
   // d = 0 keeps cnt at zero, so strobe every cycle
   assign tx_strobe = clk_cfg.tx_en & (tx_cnt == '0);
   assign rx_strobe = clk_cfg.rx_en & (rx_cnt == '0);

endmodule

`default_nettype wire

// ==== logic/ecfg_id_filter.sv ====
/*
   mesh packet filter on core id, registered pass-through of hits
   plus a saturating hit counter
*/
`timescale 1ns/1ps
`default_nettype none

module ecfg_id_filter (
   input  logic                  sys_clk,
   input  logic                  hard_reset,
   input  logic                  link_reset,
   input  ecfg_pkg::coord_t      rowid,
   input  ecfg_pkg::coord_t      colid,
   input  logic                  pkt_in_valid,
   input  ecfg_pkg::mesh_pkt_t   pkt_in,
   output logic                  pkt_out_valid,
   output ecfg_pkg::mesh_pkt_t   pkt_out,
   output ecfg_pkg::hit_count_t  hit_count
);

   import ecfg_pkg::*;

   logic pkt_hit;

   // destination matches this core
   assign pkt_hit = pkt_in_valid & (pkt_in.dst_row == rowid) & (pkt_in.dst_col == colid);

   // valid and count are control state, cleared by either reset
   always_ff @(posedge sys_clk) begin
      if (hard_reset || link_reset) begin
         pkt_out_valid <= 1'b0;
         hit_count     <= '0;
      end else begin
         pkt_out_valid <= pkt_hit;
         if (pkt_hit && (hit_count != '1))
            hit_count <= hit_count + 1'b1;  // sticks at max
      end
   end

   // payload register
   always_ff @(posedge sys_clk) begin
      if (pkt_hit)
         pkt_out <= pkt_in;
   end

endmodule

`default_nettype wire

// ==== logic/ecfg_pkg.sv ====
/*
   mesh link configuration package
   widths, register map, reset values and shared types
*/
`default_nettype none

package ecfg_pkg;

   //######################################################################
   // widths and plain vector types
   //######################################################################
   typedef logic [31:0] word_t;       // memory interface data
   typedef logic [19:0] mi_addr_t;    // full physical address, no shifting
   typedef logic [11:0] coreid_t;     // row in [11:8], col in [5:2]
   typedef logic [3:0]  coord_t;      // mesh row or column
   typedef logic [3:0]  div_t;        // clock divider value
   typedef logic [15:0] hit_count_t;  // saturating hit count

   //######################################################################
   // register map
   //######################################################################
   localparam int unsigned RFAW = 5;  // index from addr[RFAW+1:2]

   typedef logic [RFAW-1:0] reg_idx_t;

   localparam logic [3:0] CFG_GROUP = 4'h0;  // addr[19:16] must match

   localparam reg_idx_t REG_RESET   = 'd0;
   localparam reg_idx_t REG_CLK     = 'd1;
   localparam reg_idx_t REG_COREID  = 'd2;
   localparam reg_idx_t REG_VERSION = 'd3;
   localparam reg_idx_t REG_STATUS  = 'd4;  // read only

   // reset values
   localparam coreid_t     DEFAULT_COREID  = 12'h808;
   localparam logic [15:0] DEFAULT_VERSION = 16'h0000;

   localparam int unsigned RESET_HOLD = 8;  // link reset tail, in cycles

   typedef logic [$clog2(RESET_HOLD)-1:0] hold_cnt_t;

   //######################################################################
   // structs and enum
   //######################################################################
   typedef struct packed {
      logic     en;
      logic     we;    // one we, full 32 bit words only
      mi_addr_t addr;
      word_t    din;
   } mi_req_t;

   // lower 10 bits of REG_CLK, tx_div lands in bits 3:0
   typedef struct packed {
      logic rx_en;     // bit 9
      logic tx_en;     // bit 8
      div_t rx_div;    // bits 7:4
      div_t tx_div;    // bits 3:0
   } clk_cfg_t;

   typedef struct packed {
      coord_t      dst_row;
      coord_t      dst_col;
      logic [15:0] payload;
   } mesh_pkt_t;

   typedef enum logic [1:0] {
      RS_IDLE,
      RS_ACTIVE,  // follows soft reset
      RS_HOLD     // stretch after soft reset drops
   } rst_state_t;

endpackage

`default_nettype wire

// ==== logic/ecfg_regs.sv ====
/*
   mesh link configuration register file
   decodes host accesses, holds config registers, registered readback
*/
`timescale 1ns/1ps
`default_nettype none

module ecfg_regs (
   input  logic                   sys_clk,
   input  logic                   hard_reset,
   input  ecfg_pkg::mi_req_t      mi_req,
   output ecfg_pkg::word_t        mi_dout,
   input  ecfg_pkg::hit_count_t   hit_count,
   input  logic                   link_busy,
   output logic                   soft_reset,
   output ecfg_pkg::clk_cfg_t     clk_cfg,
   output ecfg_pkg::coord_t       rowid,
   output ecfg_pkg::coord_t       colid
);

   import ecfg_pkg::*;

   // config registers
   logic        reset_reg;
   logic [15:0] clk_reg;
   coreid_t     coreid_reg;
   logic [15:0] version_reg;

   // decode
   logic     group_hit;
   reg_idx_t reg_idx;
   logic     cfg_write;
   logic     cfg_read;
   logic     reset_write;
   logic     clk_write;
   logic     coreid_write;
   logic     version_write;

   //######################################################################
   // address decode
   //######################################################################
   assign group_hit = (mi_req.addr[19:16] == CFG_GROUP);
   assign reg_idx   = mi_req.addr[RFAW+1:2];  // word index

   assign cfg_write = mi_req.en &  mi_req.we & group_hit;
   assign cfg_read  = mi_req.en & ~mi_req.we & group_hit;

   // per register write enables, no entry for status
   assign reset_write   = cfg_write & (reg_idx == REG_RESET);
   assign clk_write     = cfg_write & (reg_idx == REG_CLK);
   assign coreid_write  = cfg_write & (reg_idx == REG_COREID);
   assign version_write = cfg_write & (reg_idx == REG_VERSION);

   //######################################################################
   // configuration registers
   //######################################################################
   always_ff @(posedge sys_clk) begin
      if (hard_reset) begin
         reset_reg   <= 1'b0;
         clk_reg     <= '0;               // both channels off
         coreid_reg  <= DEFAULT_COREID;
         version_reg <= DEFAULT_VERSION;
      end else begin
         if (reset_write)
            reset_reg <= mi_req.din[0];
         if (clk_write)
            clk_reg <= mi_req.din[15:0];
         if (coreid_write)
            coreid_reg <= mi_req.din[11:0];
         if (version_write)
            version_reg <= mi_req.din[15:0];
      end
   end

   assign soft_reset = reset_reg;
   assign clk_cfg    = clk_cfg_t'(clk_reg[9:0]);  // upper bits stored, unused
   assign colid      = coreid_reg[5:2];
   assign rowid      = coreid_reg[11:8];

   //######################################################################
   // readback, one cycle after the request
   //######################################################################
   always_ff @(posedge sys_clk) begin
      if (hard_reset) begin
         mi_dout <= '0;
      end else if (cfg_read) begin
         case (reg_idx)
            REG_RESET:   mi_dout <= {31'b0, reset_reg};
            REG_CLK:     mi_dout <= {16'b0, clk_reg};
            REG_COREID:  mi_dout <= {20'b0, coreid_reg};
            REG_VERSION: mi_dout <= {16'b0, version_reg};
            REG_STATUS:  mi_dout <= {15'b0, link_busy, hit_count};  // live status
            default:     mi_dout <= '0;  // unused index
         endcase
      end
      // no read, dout holds
   end

endmodule

`default_nettype wire

// ==== logic/ecfg_reset_seq.sv ====
/*
   link reset sequencer, stretches soft reset by RESET_HOLD cycles
*/
`timescale 1ns/1ps
`default_nettype none

module ecfg_reset_seq (
   input  logic sys_clk,
   input  logic hard_reset,
   input  logic soft_reset,
   output logic link_reset
);

   import ecfg_pkg::*;

   rst_state_t state;
   hold_cnt_t  hold_cnt;  // counts down the tail

   always_ff @(posedge sys_clk) begin
      if (hard_reset) begin
         state    <= RS_IDLE;
         hold_cnt <= '0;
      end else begin
         case (state)
            RS_IDLE: begin
               if (soft_reset)
                  state <= RS_ACTIVE;
            end
            RS_ACTIVE: begin
               if (!soft_reset) begin
                  state    <= RS_HOLD;
                  hold_cnt <= hold_cnt_t'(RESET_HOLD - 1);
               end
            end
            RS_HOLD: begin
               if (soft_reset)
                  state <= RS_ACTIVE;  // re-armed before tail ends
               else if (hold_cnt == '0)
                  state <= RS_IDLE;
               else
                  hold_cnt <= hold_cnt - 1'b1;
            end
            default: state <= RS_IDLE;
         endcase
      end
   end

   assign link_reset = (state != RS_IDLE);  // one cycle behind soft reset

endmodule

`default_nettype wire

// ==== logic/ecfg_top.sv ====
/*
   mesh link configuration block top, register file plus datapath
*/
`timescale 1ns/1ps
`default_nettype none

module ecfg_top (
   input  logic                 sys_clk,
   input  logic                 hard_reset,
   input  ecfg_pkg::mi_req_t    mi_req,
   output ecfg_pkg::word_t      mi_dout,
   output logic                 tx_strobe,
   output logic                 rx_strobe,
   output logic                 link_reset,
   input  logic                 pkt_in_valid,
   input  ecfg_pkg::mesh_pkt_t  pkt_in,
   output logic                 pkt_out_valid,
   output ecfg_pkg::mesh_pkt_t  pkt_out
);

   import ecfg_pkg::*;

   // register file to datapath
   logic       soft_reset;
   clk_cfg_t   clk_cfg;
   coord_t     rowid;
   coord_t     colid;
   hit_count_t hit_count;   // back into status

   ecfg_regs ecfg_regs_inst (
      .sys_clk    (sys_clk),
      .hard_reset (hard_reset),
      .mi_req     (mi_req),
      .mi_dout    (mi_dout),
      .hit_count  (hit_count),
      .link_busy  (link_reset),  // busy is the link reset
      .soft_reset (soft_reset),
      .clk_cfg    (clk_cfg),
      .rowid      (rowid),
      .colid      (colid)
   );

   ecfg_clkdiv ecfg_clkdiv_inst (
      .sys_clk    (sys_clk),
      .hard_reset (hard_reset),
      .clk_cfg    (clk_cfg),
      .tx_strobe  (tx_strobe),
      .rx_strobe  (rx_strobe)
   );

   ecfg_reset_seq ecfg_reset_seq_inst (
      .sys_clk    (sys_clk),
      .hard_reset (hard_reset),
      .soft_reset (soft_reset),
      .link_reset (link_reset)
   );

   ecfg_id_filter ecfg_id_filter_inst (
      .sys_clk       (sys_clk),
      .hard_reset    (hard_reset),
      .link_reset    (link_reset),
      .rowid         (rowid),
      .colid         (colid),
      .pkt_in_valid  (pkt_in_valid),
      .pkt_in        (pkt_in),
      .pkt_out_valid (pkt_out_valid),
      .pkt_out       (pkt_out),
      .hit_count     (hit_count)
   );

endmodule

`default_nettype wire

// ==== src.f ====
logic/ecfg_pkg.sv
logic/ecfg_regs.sv
logic/ecfg_clkdiv.sv
logic/ecfg_reset_seq.sv
logic/ecfg_id_filter.sv
logic/ecfg_top.sv
test/ecfg_assert.sv
test/ecfg_tb.sv

// ==== test/ecfg_assert.sv ====
/*
   concurrent checks on the configuration block, bound into ecfg_top
*/
`timescale 1ns/1ps
`default_nettype none

module ecfg_assert (
   input logic                sys_clk,
   input logic                hard_reset,
   input ecfg_pkg::mi_req_t   mi_req,
   input ecfg_pkg::word_t     mi_dout,
   input ecfg_pkg::clk_cfg_t  clk_cfg,
   input logic                tx_strobe,
   input logic                rx_strobe,
   input logic                soft_reset,
   input logic                link_reset,
   input ecfg_pkg::coord_t    rowid,
   input ecfg_pkg::coord_t    colid,
   input logic                pkt_in_valid,
   input ecfg_pkg::mesh_pkt_t pkt_in,
   input logic                pkt_out_valid
);

   import ecfg_pkg::*;

   int unsigned fail_count = 0;

   logic pkt_match;
   logic mi_read_req;

   assign pkt_match   = pkt_in_valid & (pkt_in.dst_row == rowid) & (pkt_in.dst_col == colid);
   assign mi_read_req = mi_req.en & ~mi_req.we & (mi_req.addr[19:16] == CFG_GROUP);

   // disabled channel stays quiet, and restarts on a cleared counter
   strobe_off: assert property (@(posedge sys_clk) disable iff (hard_reset)
      ($past(clk_cfg.tx_en) | (tx_strobe == clk_cfg.tx_en)) &
      ($past(clk_cfg.rx_en) | (rx_strobe == clk_cfg.rx_en)))
      else begin
         $error("strobe on a disabled channel or missing after enable");
         fail_count++;
      end

   // one active cycle, then RESET_HOLD cycles of tail
   hold_tail: assert property (@(posedge sys_clk) disable iff (hard_reset)
      $fell(soft_reset) |-> ##RESET_HOLD link_reset ##1 !link_reset)
      else begin
         $error("link reset tail has the wrong length");
         fail_count++;
      end

   // output packet only from a match outside link reset
   pkt_source: assert property (@(posedge sys_clk) disable iff (hard_reset)
      pkt_out_valid |-> $past(pkt_match & ~link_reset))
      else begin
         $error("pkt_out_valid without a matching input");
         fail_count++;
      end

   dout_hold: assert property (@(posedge sys_clk) disable iff (hard_reset)
      !$stable(mi_dout) |-> $past(mi_read_req))
      else begin
         $error("mi_dout changed without a read");
         fail_count++;
      end

endmodule

bind ecfg_top ecfg_assert ecfg_assert_inst (
   .sys_clk       (sys_clk),
   .hard_reset    (hard_reset),
   .mi_req        (mi_req),
   .mi_dout       (mi_dout),
   .clk_cfg       (clk_cfg),
   .tx_strobe     (tx_strobe),
   .rx_strobe     (rx_strobe),
   .soft_reset    (soft_reset),
   .link_reset    (link_reset),
   .rowid         (rowid),
   .colid         (colid),
   .pkt_in_valid  (pkt_in_valid),
   .pkt_in        (pkt_in),
   .pkt_out_valid (pkt_out_valid)
);

`default_nettype wire

// ==== test/ecfg_tb.sv ====
/*
   testbench for the mesh link configuration block
   register access, clock strobes, soft reset and packet filter
*/
`timescale 1ns/1ps
`default_nettype none

module ecfg_tb;

   import ecfg_pkg::*;

   localparam int CLK_PERIOD  = 10;
   localparam int GAP_ROUNDS  = 4;
   localparam int STROBE_WAIT = 60;   // three strobes at divider 15
   localparam int LINK_WAIT   = 40;
   localparam int PKT_COUNT   = 40;
   // sum of the worst case test lengths, plus margin
   localparam int RUN_CYCLES  = 40 + 60 + GAP_ROUNDS * (2 * STROBE_WAIT + 60)
                                + 2 * LINK_WAIT + 3 * PKT_COUNT + 200;

   logic      sys_clk;
   logic      hard_reset;
   mi_req_t   mi_req;
   word_t     mi_dout;
   logic      tx_strobe;
   logic      rx_strobe;
   logic      link_reset;
   logic      pkt_in_valid;
   mesh_pkt_t pkt_in;
   logic      pkt_out_valid;
   mesh_pkt_t pkt_out;

   string test_name;
   int    test_errors;
   int    total_errors;
   int    tests_run;
   int    tests_bad;
   int    link_cycles;  // link_reset high samples

   ecfg_top ecfg_top_inst (
      .sys_clk       (sys_clk),
      .hard_reset    (hard_reset),
      .mi_req        (mi_req),
      .mi_dout       (mi_dout),
      .tx_strobe     (tx_strobe),
      .rx_strobe     (rx_strobe),
      .link_reset    (link_reset),
      .pkt_in_valid  (pkt_in_valid),
      .pkt_in        (pkt_in),
      .pkt_out_valid (pkt_out_valid),
      .pkt_out       (pkt_out)
   );

   initial sys_clk = 1'b0;
   always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

   always @(negedge sys_clk) begin
      if (link_reset)
         link_cycles++;
   end

   //######################################################################
   // helpers
   //######################################################################
   task automatic compare_value(input string what, input word_t expected, input word_t actual);
      assert (actual === expected) else begin
         $display("Mismatch in %s, %s: expected 0x%0h, actual 0x%0h",
                  test_name, what, expected, actual);
         test_errors++;
      end
   endtask

   function automatic mi_addr_t reg_addr(input logic [3:0] group, input int idx);
      return {group, 16'(idx * 4)};  // word index at addr[6:2]
   endfunction

   task automatic mi_write(input mi_addr_t addr, input word_t data);
      mi_req = '{en: 1'b1, we: 1'b1, addr: addr, din: data};
      @(negedge sys_clk);
      mi_req.en = 1'b0;
   endtask

   // drive the read, sample one edge later
   task automatic read_expect(input string what, input int idx, input word_t expected);
      mi_req = '{en: 1'b1, we: 1'b0, addr: reg_addr(CFG_GROUP, idx), din: '0};
      @(negedge sys_clk);
      mi_req.en = 1'b0;
      compare_value(what, expected, mi_dout);
   endtask

   // mask bits are tx, rx, link, pkt_out_valid
   task automatic watch_idle(input string what, input int cycles, input logic [3:0] mask);
      repeat (cycles) begin
         @(negedge sys_clk);
         compare_value(what, 32'h0,
                       32'({tx_strobe, rx_strobe, link_reset, pkt_out_valid} & mask));
      end
   endtask

   task automatic strobe_gap(input logic rx_side, output int gap);
      int seen;
      int last;
      int cyc;
      seen = 0;
      last = 0;
      gap  = -1;                       // stays -1 if fewer than two strobes
      for (cyc = 0; cyc < STROBE_WAIT && seen < 3; cyc++) begin
         @(negedge sys_clk);
         if (rx_side ? rx_strobe : tx_strobe) begin
            if (seen > 0)
               gap = cyc - last;
            last = cyc;
            seen++;
         end
      end
   endtask

   task automatic wait_link_release();
      int n;
      n = 0;
      while (link_reset && n < LINK_WAIT) begin
         @(negedge sys_clk);
         n++;
      end
      assert (!link_reset) else begin
         $display("link reset still high after %0d cycles in %s", LINK_WAIT, test_name);
         test_errors++;
      end
   endtask

   // back to back packets, each output checked one cycle after its input
   task automatic send_packets(input int count, input coord_t row, input coord_t col,
                               input coord_t alt_row, input coord_t alt_col, inout int hits);
      mesh_pkt_t pkt;
      mesh_pkt_t prev;
      logic      prev_hit;
      int        i;
      prev_hit = 1'b0;
      prev     = '0;
      for (i = 0; i <= count; i++) begin
         compare_value("pkt_out_valid", 32'(prev_hit), 32'(pkt_out_valid));
         if (prev_hit)
            compare_value("pkt_out", 32'(prev), 32'(pkt_out));
         if (i < count) begin
            pkt.payload = 16'($urandom);
            case ($urandom % 3)
               0:       {pkt.dst_row, pkt.dst_col} = {row, col};
               1:       {pkt.dst_row, pkt.dst_col} = {alt_row, alt_col};
               default: {pkt.dst_row, pkt.dst_col} = 8'($urandom);
            endcase
            prev_hit = (pkt.dst_row == row) && (pkt.dst_col == col);
            hits += int'(prev_hit);
            prev         = pkt;
            pkt_in       = pkt;
            pkt_in_valid = 1'b1;
         end else begin
            pkt_in_valid = 1'b0;
            prev_hit     = 1'b0;
         end
         @(negedge sys_clk);
      end
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic finish_test();
      tests_run++;
      total_errors += test_errors;
      if (test_errors != 0)
         tests_bad++;
      $display("%-16s %s", test_name, (test_errors == 0) ? "PASS" : "FAIL");
   endtask

   //######################################################################
   // test sequence
   //######################################################################
   initial begin
      word_t      wdata;
      int         gap;
      int         hits;
      int         hold_len;
      int         round;
      logic [3:0] dtx;
      logic [3:0] drx;
      coord_t     nrow;
      coord_t     ncol;
      void'($urandom(78369));
      hard_reset   = 1'b1;
      mi_req       = '0;
      pkt_in_valid = 1'b0;
      pkt_in       = '0;
      test_errors  = 0;
      total_errors = 0;
      tests_run    = 0;
      tests_bad    = 0;
      link_cycles  = 0;
      repeat (3) @(negedge sys_clk);
      hard_reset = 1'b0;

      start_test("reset_values");
      read_expect("coreid", REG_COREID, 32'h808);
      read_expect("version", REG_VERSION, 32'h0);
      read_expect("clk", REG_CLK, 32'h0);
      read_expect("status", REG_STATUS, 32'h0);
      watch_idle("idle outputs", 10, 4'b1111);
      finish_test();

      start_test("register_access");
      wdata = $urandom & 32'h1;
      mi_write(reg_addr(CFG_GROUP, REG_RESET), wdata);
      read_expect("reset", REG_RESET, wdata);
      mi_write(reg_addr(CFG_GROUP, REG_RESET), wdata ^ 32'h1);  // both bit values
      read_expect("reset flipped", REG_RESET, wdata ^ 32'h1);
      mi_write(reg_addr(CFG_GROUP, REG_RESET), 32'h0);
      wait_link_release();
      wdata = $urandom & 32'hffff;
      mi_write(reg_addr(CFG_GROUP, REG_CLK), wdata);
      read_expect("clk", REG_CLK, wdata);
      mi_write(reg_addr(CFG_GROUP, REG_CLK), 32'h0);
      wdata = $urandom & 32'hfff;
      mi_write(reg_addr(CFG_GROUP, REG_COREID), wdata);
      read_expect("coreid", REG_COREID, wdata);
      mi_write(reg_addr(CFG_GROUP, REG_COREID), 32'h808);
      wdata = $urandom & 32'hffff;
      mi_write(reg_addr(CFG_GROUP, REG_VERSION), wdata);
      read_expect("version", REG_VERSION, wdata);
      mi_write(reg_addr(4'h1, REG_VERSION), ~wdata);  // other group, no effect
      read_expect("version after other group", REG_VERSION, wdata);
      mi_write(reg_addr(CFG_GROUP, REG_STATUS), $urandom);
      read_expect("status after write", REG_STATUS, 32'h0);
      read_expect("unused index", 5 + int'($urandom % 27), 32'h0);
      finish_test();

      start_test("clock_strobes");
      for (round = 0; round < GAP_ROUNDS; round++) begin
         dtx = 4'($urandom);
         drx = 4'($urandom);
         mi_write(reg_addr(CFG_GROUP, REG_CLK), {22'b0, 2'b11, drx, dtx});
         strobe_gap(1'b0, gap);
         compare_value("tx gap", 32'(dtx) + 32'd1, 32'(gap));
         strobe_gap(1'b1, gap);
         compare_value("rx gap", 32'(drx) + 32'd1, 32'(gap));
      end
      mi_write(reg_addr(CFG_GROUP, REG_CLK), {22'b0, 2'b10, drx, dtx});  // rx only
      watch_idle("tx while disabled", 20, 4'b1000);
      mi_write(reg_addr(CFG_GROUP, REG_CLK), 32'h0);
      watch_idle("strobes while disabled", 20, 4'b1100);
      finish_test();

      start_test("soft_reset");
      hits = 0;
      send_packets(4, 4'h8, 4'h2, 4'h8, 4'h2, hits);  // all for core 0x808
      read_expect("hits before reset", REG_STATUS, 32'(hits));
      hold_len    = 1 + int'($urandom % 8);
      link_cycles = 0;
      mi_write(reg_addr(CFG_GROUP, REG_RESET), 32'h1);
      repeat (2) @(negedge sys_clk);  // let the count clear
      read_expect("busy", REG_STATUS, 32'h1_0000);
      repeat (hold_len) @(negedge sys_clk);
      mi_write(reg_addr(CFG_GROUP, REG_RESET), 32'h0);
      wait_link_release();
      // soft reset high for hold_len + 4 cycles, then the tail
      compare_value("link reset length", 32'(hold_len + 4 + RESET_HOLD), 32'(link_cycles));
      read_expect("status after reset", REG_STATUS, 32'h0);
      finish_test();

      start_test("packet_filter");
      hits = 0;
      nrow = 4'($urandom);
      ncol = 4'($urandom);
      if ({nrow, ncol} == 8'h82)
         nrow = ~nrow;                 // new id must differ
      send_packets(PKT_COUNT, 4'h8, 4'h2, nrow, ncol, hits);
      read_expect("hit count", REG_STATUS, 32'(hits));
      mi_write(reg_addr(CFG_GROUP, REG_COREID), {20'b0, nrow, 2'b0, ncol, 2'b0});
      send_packets(PKT_COUNT, nrow, ncol, 4'h8, 4'h2, hits);  // old id now misses
      read_expect("hit count after id change", REG_STATUS, 32'(hits));
      finish_test();

      $display("%0d tests run, %0d failing, %0d check errors, %0d assertion errors",
               tests_run, tests_bad, total_errors, ecfg_top_inst.ecfg_assert_inst.fail_count);
      if (tests_bad == 0 && ecfg_top_inst.ecfg_assert_inst.fail_count == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   // watchdog
   initial begin
      #(RUN_CYCLES * CLK_PERIOD);
      $display("timeout, run did not finish within %0d cycles", RUN_CYCLES);
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire
